//--- conv_geom_pkg.sv
`default_nettype none

package conv_geom_pkg;

    //////////////////////////////////////////////////
    // Layer geometry
    //////////////////////////////////////////////////
    localparam int ACT_DIM  = 28;  // Activation map side
    localparam int FILT_DIM = 16;  // Full filter side
    localparam int BLK_DIM  = 8;   // One weight block side
    localparam int OUT_DIM  = 13;  // Partial-sum map side
    localparam int NUM_PE   = 8;   // PEs in the row

    // GB holds eight activation rows at a time
    localparam int GB_ACT_DEPTH = 224;

    // Activation columns fetched per row of a block
    localparam int ACT_LOAD_COLS = 20;
    localparam int NUM_BLOCKS    = 4;   // 2x2 split of the filter

    //////////////////////////////////////////////////
    // Region bases
    //////////////////////////////////////////////////
    localparam int MEM_ACT_BASE  = 0;
    localparam int MEM_W_BASE    = 800;   // 16x16 filter, row major
    localparam int MEM_PSUM_BASE = 1100;  // 13x13 result

    localparam int GB_ACT_BASE  = 0;
    localparam int GB_W_BASE    = 224;  // One 8x8 block
    localparam int GB_PSUM_BASE = 288;

    // Transfers per phase
    localparam int W_XFERS      = BLK_DIM * BLK_DIM;        // 64
    localparam int ACT_XFERS    = ACT_LOAD_COLS * BLK_DIM;  // 160
    localparam int RESULT_XFERS = OUT_DIM * OUT_DIM;        // 169

endpackage

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // Controller phases
    typedef enum logic [3:0] {
        INIT       = 4'd0,
        LOAD_W     = 4'd1,   // Memory to GB, weights
        LOAD_ACT   = 4'd2,   // Memory to GB, eight activation rows
        BCAST_W    = 4'd3,   // GB to PEs, weights
        STREAM_ACT = 4'd4,   // GB to PEs, first full run
        STEP_COL   = 4'd5,   // One new column
        SHIFT      = 4'd6,
        PSUM       = 4'd7,   // Wait, then PE to GB
        REFILL_ROW = 4'd8,   // Replace oldest GB row
        WRITEBACK  = 4'd9,   // GB to memory, results
        FINISHED   = 4'd10
    } phase_e;

    // Bit 0 right half, bit 1 lower half
    typedef logic [1:0] block_t;

    // Weight transfer index
    // flat is the GB offset, rc the position inside the 8x8 block
    typedef union packed {
        logic [5:0] flat;
        struct packed {
            logic [2:0] row;
            logic [2:0] col;
        } rc;
    } w_idx_u;

    typedef logic [7:0] cnt8_t;
    typedef logic [3:0] pos4_t;   // Row or column, 0 to 12

endpackage

`default_nettype wire

//--- conv_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module conv_sequencer #(
    parameter int PSUM_WAIT = 12
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             done_mem,
    input  logic             done_gb,
    input  ctrl_pkg::w_idx_u w_idx,
    input  ctrl_pkg::cnt8_t  act_gb_cnt,
    input  ctrl_pkg::pos4_t  w_pe_cnt,
    input  ctrl_pkg::pos4_t  act_pe_cnt,
    input  ctrl_pkg::cnt8_t  psum_cnt,
    input  logic [4:0]       wait_cnt,
    input  ctrl_pkg::cnt8_t  result_cnt,
    output ctrl_pkg::phase_e phase,
    output ctrl_pkg::block_t block,
    output ctrl_pkg::pos4_t  row,
    output ctrl_pkg::pos4_t  col,
    output logic             init,
    output logic             read_mem,
    output logic             write_mem,
    output logic             read_gb,
    output logic             write_pe_to_gb,
    output logic             write_mem_to_gb,
    output logic             finished
);

    localparam int LAST_POS = conv_geom_pkg::OUT_DIM - 1;

    logic psum_wait_over;
    logic psum_done;

    assign psum_wait_over = (wait_cnt >= 5'(PSUM_WAIT));
    assign psum_done      = (phase == ctrl_pkg::PSUM) && psum_wait_over && done_gb;

    //////////////////////////////////////////////////
    // Phase progression
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ctrl_pkg::INIT;
            block <= '0;
            row   <= '0;
            col   <= '0;
        end else begin
            case (phase)
                ctrl_pkg::INIT: phase <= ctrl_pkg::LOAD_W;
                ctrl_pkg::LOAD_W: begin
                    row <= '0;   // New block starts at the top
                    if (done_mem && w_idx.flat == 6'(conv_geom_pkg::W_XFERS - 1))
                        phase <= ctrl_pkg::LOAD_ACT;
                end
                ctrl_pkg::LOAD_ACT: begin
                    if (done_mem && act_gb_cnt == 8'(conv_geom_pkg::ACT_XFERS - 1))
                        phase <= ctrl_pkg::BCAST_W;
                end
                ctrl_pkg::BCAST_W: begin
                    if (done_gb && w_pe_cnt == 4'(conv_geom_pkg::NUM_PE - 1))
                        phase <= ctrl_pkg::STREAM_ACT;
                end
                ctrl_pkg::STREAM_ACT: begin
                    col <= '0;
                    if (done_gb && act_pe_cnt == 4'(conv_geom_pkg::NUM_PE - 1))
                        phase <= ctrl_pkg::SHIFT;
                end
                ctrl_pkg::STEP_COL: if (done_gb) phase <= ctrl_pkg::SHIFT;
                ctrl_pkg::SHIFT:    phase <= ctrl_pkg::PSUM;
                ctrl_pkg::PSUM: begin
                    if (psum_done) begin
                        if (col < 4'(LAST_POS)) begin
                            col   <= col + 4'd1;
                            phase <= ctrl_pkg::STEP_COL;
                        end else if (row < 4'(LAST_POS)) begin
                            phase <= ctrl_pkg::REFILL_ROW;
                        end else if (block < 2'(conv_geom_pkg::NUM_BLOCKS - 1)) begin
                            block <= block + 2'd1;
                            phase <= ctrl_pkg::LOAD_W;
                        end else begin
                            phase <= ctrl_pkg::WRITEBACK;
                        end
                    end
                end
                ctrl_pkg::REFILL_ROW: begin
                    if (done_mem && act_gb_cnt == 8'(conv_geom_pkg::ACT_LOAD_COLS - 1)) begin
                        row   <= row + 4'd1;
                        phase <= ctrl_pkg::STREAM_ACT;
                    end
                end
                ctrl_pkg::WRITEBACK: begin
                    if (done_mem && result_cnt == 8'(conv_geom_pkg::RESULT_XFERS - 1))
                        phase <= ctrl_pkg::FINISHED;
                end
                default: phase <= ctrl_pkg::FINISHED;   // Stays here
            endcase
        end
    end

    // Strobes
    assign init            = (phase == ctrl_pkg::INIT);
    assign read_mem        = (phase == ctrl_pkg::LOAD_W) || (phase == ctrl_pkg::LOAD_ACT) ||
                             (phase == ctrl_pkg::REFILL_ROW);
    assign write_mem_to_gb = read_mem;   // Every memory read lands in the GB
    assign write_mem       = (phase == ctrl_pkg::WRITEBACK);
    assign read_gb         = (phase == ctrl_pkg::BCAST_W) || (phase == ctrl_pkg::STREAM_ACT) ||
                             (phase == ctrl_pkg::STEP_COL) || (phase == ctrl_pkg::WRITEBACK) ||
                             ((phase == ctrl_pkg::PSUM) && !psum_wait_over);
    assign write_pe_to_gb  = (phase == ctrl_pkg::PSUM) && psum_wait_over;
    assign finished        = (phase == ctrl_pkg::FINISHED);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    a_gb_port_excl: assert property (@(posedge clk) disable iff (rst)
        !(write_pe_to_gb && read_gb));

    a_block_in_psum: assert property (@(posedge clk) disable iff (rst)
        $changed(block) |-> $past(phase) == ctrl_pkg::PSUM);

    // Last psum write of a block hits the last result slot
    a_psum_count: assert property (@(posedge clk) disable iff (rst)
        (psum_done && col == 4'(LAST_POS) && row == 4'(LAST_POS)) |->
        psum_cnt == 8'(conv_geom_pkg::RESULT_XFERS - 1));

endmodule

`default_nettype wire

//--- transfer_counters.sv
`timescale 1ns/10ps
`default_nettype none

module transfer_counters #(
    parameter int PSUM_WAIT = 12
) (
    input  logic             clk,
    input  logic             rst,
    input  ctrl_pkg::phase_e phase,
    input  logic             done_mem,
    input  logic             done_gb,
    input  logic             write_pe_to_gb,
    output ctrl_pkg::w_idx_u w_idx,
    output ctrl_pkg::cnt8_t  act_gb_cnt,
    output ctrl_pkg::cnt8_t  psum_cnt,
    output ctrl_pkg::cnt8_t  result_cnt,
    output ctrl_pkg::pos4_t  w_pe_cnt,
    output ctrl_pkg::pos4_t  act_pe_cnt,
    output logic [4:0]       wait_cnt
);

    logic act_load;

    // Full load and row refill share the activation counter
    assign act_load = (phase == ctrl_pkg::LOAD_ACT) || (phase == ctrl_pkg::REFILL_ROW);

    always_ff @(posedge clk) begin
        if (rst) begin
            w_idx      <= '0;
            act_gb_cnt <= '0;
            w_pe_cnt   <= '0;
            act_pe_cnt <= '0;
            wait_cnt   <= '0;
            psum_cnt   <= '0;
            result_cnt <= '0;
        end else begin
            // Memory to GB
            if (phase == ctrl_pkg::LOAD_W) begin
                if (done_mem) w_idx.flat <= w_idx.flat + 6'd1;
            end else begin
                w_idx <= '0;
            end

            if (act_load) begin
                if (done_mem) act_gb_cnt <= act_gb_cnt + 8'd1;
            end else begin
                act_gb_cnt <= '0;
            end

            // GB to PEs
            if (phase == ctrl_pkg::BCAST_W) begin
                if (done_gb) w_pe_cnt <= w_pe_cnt + 4'd1;
            end else begin
                w_pe_cnt <= '0;
            end

            if (phase == ctrl_pkg::STREAM_ACT) begin
                if (done_gb) act_pe_cnt <= act_pe_cnt + 4'd1;
            end else begin
                act_pe_cnt <= '0;
            end

            // Psum wait, holds at the limit during the write
            if (phase == ctrl_pkg::PSUM) begin
                if (wait_cnt < 5'(PSUM_WAIT)) wait_cnt <= wait_cnt + 5'd1;
            end else begin
                wait_cnt <= '0;
            end

            // Psum slot, kept across rows and columns of one block
            if (phase == ctrl_pkg::LOAD_W)
                psum_cnt <= '0;
            else if (phase == ctrl_pkg::PSUM && write_pe_to_gb && done_gb)
                psum_cnt <= psum_cnt + 8'd1;

            if (phase == ctrl_pkg::WRITEBACK && done_mem)
                result_cnt <= result_cnt + 8'd1;
        end
    end

    // The sequencer must leave LOAD_W on the 64th pulse
    a_w_idx_nowrap: assert property (@(posedge clk) disable iff (rst)
        (phase == ctrl_pkg::LOAD_W && done_mem && w_idx.flat == 6'd63) |=>
        phase == ctrl_pkg::LOAD_ACT);

endmodule

`default_nettype wire

//--- mem_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module mem_addr_gen #(
    parameter int ADDR_W = 12
) (
    input  ctrl_pkg::phase_e    phase,
    input  ctrl_pkg::block_t    block,
    input  ctrl_pkg::pos4_t     row,
    input  ctrl_pkg::w_idx_u    w_idx,
    input  ctrl_pkg::cnt8_t     act_gb_cnt,
    input  ctrl_pkg::cnt8_t     result_cnt,
    output logic [ADDR_W-1:0]   mem_addr
);

    always_comb begin
        int right_off;
        int lower_row;
        int act_row;
        int act_col;

        right_off = block[0] ? conv_geom_pkg::BLK_DIM : 0;
        lower_row = block[1] ? conv_geom_pkg::BLK_DIM : 0;
        act_row   = int'(act_gb_cnt) / conv_geom_pkg::ACT_LOAD_COLS;
        act_col   = int'(act_gb_cnt) % conv_geom_pkg::ACT_LOAD_COLS;

        case (phase)
            ctrl_pkg::LOAD_W:   // Row and column of the block inside the 16x16 filter
                mem_addr = ADDR_W'(conv_geom_pkg::MEM_W_BASE +
                    conv_geom_pkg::FILT_DIM * (int'(w_idx.rc.row) + lower_row) +
                    int'(w_idx.rc.col) + right_off);
            ctrl_pkg::LOAD_ACT:
                mem_addr = ADDR_W'(conv_geom_pkg::MEM_ACT_BASE +
                    conv_geom_pkg::ACT_DIM * (act_row + lower_row) + act_col + right_off);
            ctrl_pkg::REFILL_ROW:   // Next row below the eight held in the GB
                mem_addr = ADDR_W'(conv_geom_pkg::MEM_ACT_BASE + conv_geom_pkg::GB_ACT_DEPTH +
                    conv_geom_pkg::ACT_DIM * (int'(row) + lower_row) +
                    int'(act_gb_cnt) + right_off);
            ctrl_pkg::WRITEBACK:
                mem_addr = ADDR_W'(conv_geom_pkg::MEM_PSUM_BASE + int'(result_cnt));
            default:
                mem_addr = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- gb_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module gb_addr_gen #(
    parameter int ADDR_W = 12
) (
    input  ctrl_pkg::phase_e  phase,
    input  ctrl_pkg::block_t  block,
    input  ctrl_pkg::pos4_t   row,
    input  ctrl_pkg::pos4_t   col,
    input  ctrl_pkg::w_idx_u  w_idx,
    input  ctrl_pkg::cnt8_t   act_gb_cnt,
    input  ctrl_pkg::pos4_t   w_pe_cnt,
    input  ctrl_pkg::pos4_t   act_pe_cnt,
    input  ctrl_pkg::cnt8_t   psum_cnt,
    input  ctrl_pkg::cnt8_t   result_cnt,
    output logic [ADDR_W-1:0] gb_addr_write,
    output logic [ADDR_W-1:0] gb_addr_psum,
    output logic [ADDR_W-1:0] gb_addr_mem,
    output logic [ADDR_W-1:0] gb_addr_pe [conv_geom_pkg::NUM_PE]
);

    logic [ADDR_W-1:0] psum_addr;
    int                right_off;

    assign right_off = block[0] ? conv_geom_pkg::BLK_DIM : 0;
    assign psum_addr = ADDR_W'(conv_geom_pkg::GB_PSUM_BASE + int'(psum_cnt));

    //////////////////////////////////////////////////
    // Write side and psum ports
    //////////////////////////////////////////////////
    always_comb begin
        case (phase)
            ctrl_pkg::LOAD_W:
                gb_addr_write = ADDR_W'(conv_geom_pkg::GB_W_BASE + int'(w_idx.flat));
            ctrl_pkg::LOAD_ACT:
                gb_addr_write = ADDR_W'(conv_geom_pkg::GB_ACT_BASE +
                    int'(act_gb_cnt) / conv_geom_pkg::ACT_LOAD_COLS * conv_geom_pkg::ACT_DIM +
                    int'(act_gb_cnt) % conv_geom_pkg::ACT_LOAD_COLS + right_off);
            ctrl_pkg::REFILL_ROW:   // Overwrites the row no longer needed
                gb_addr_write = ADDR_W'(conv_geom_pkg::GB_ACT_BASE +
                    (conv_geom_pkg::ACT_DIM * int'(row) + int'(act_gb_cnt) + right_off) %
                    conv_geom_pkg::GB_ACT_DEPTH);
            ctrl_pkg::PSUM:
                gb_addr_write = psum_addr;
            default:
                gb_addr_write = '0;
        endcase
    end

    assign gb_addr_psum = (phase == ctrl_pkg::PSUM) ? psum_addr : '0;
    assign gb_addr_mem  = (phase == ctrl_pkg::WRITEBACK) ?
                          ADDR_W'(conv_geom_pkg::GB_PSUM_BASE + int'(result_cnt)) : '0;

    //////////////////////////////////////////////////
    // PE read ports
    //////////////////////////////////////////////////
    always_comb begin
        int act_pos;

        // Column offset inside the activation window
        act_pos = (phase == ctrl_pkg::STEP_COL) ?
                  int'(col) + conv_geom_pkg::BLK_DIM - 1 : int'(act_pe_cnt);
        for (int k = 0; k < conv_geom_pkg::NUM_PE; k++) begin
            case (phase)
                ctrl_pkg::BCAST_W:   // PE k takes weight row k
                    gb_addr_pe[k] = ADDR_W'(conv_geom_pkg::GB_W_BASE + int'(w_pe_cnt) +
                        conv_geom_pkg::BLK_DIM * k);
                ctrl_pkg::STREAM_ACT, ctrl_pkg::STEP_COL:
                    gb_addr_pe[k] = ADDR_W'(conv_geom_pkg::GB_ACT_BASE +
                        (act_pos + conv_geom_pkg::ACT_DIM * (k + int'(row)) + right_off) %
                        conv_geom_pkg::GB_ACT_DEPTH);
                default:
                    gb_addr_pe[k] = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- conv_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_ctrl_top #(
    parameter int ADDR_W    = 12,
    parameter int PSUM_WAIT = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              done_mem,
    input  logic              done_gb,
    output logic              read_mem,
    output logic              write_mem,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              read_gb,
    output logic              write_pe_to_gb,
    output logic              write_mem_to_gb,
    output logic [ADDR_W-1:0] gb_addr_write,
    output logic [ADDR_W-1:0] gb_addr_psum,
    output logic [ADDR_W-1:0] gb_addr_mem,
    output logic [ADDR_W-1:0] gb_addr_pe [conv_geom_pkg::NUM_PE],
    output logic              init,
    output logic              finished
);

    ctrl_pkg::phase_e phase;
    ctrl_pkg::block_t block;
    ctrl_pkg::pos4_t  row, col;
    ctrl_pkg::w_idx_u w_idx;
    ctrl_pkg::cnt8_t  act_gb_cnt, psum_cnt, result_cnt;
    ctrl_pkg::pos4_t  w_pe_cnt, act_pe_cnt;
    logic [4:0]       wait_cnt;

    conv_sequencer #(.PSUM_WAIT(PSUM_WAIT)) u_seq (
        .clk, .rst, .done_mem, .done_gb,
        .w_idx, .act_gb_cnt, .w_pe_cnt, .act_pe_cnt, .psum_cnt, .wait_cnt, .result_cnt,
        .phase, .block, .row, .col,
        .init, .read_mem, .write_mem, .read_gb, .write_pe_to_gb, .write_mem_to_gb, .finished
    );

    transfer_counters #(.PSUM_WAIT(PSUM_WAIT)) u_cnt (
        .clk, .rst, .phase, .done_mem, .done_gb, .write_pe_to_gb,
        .w_idx, .act_gb_cnt, .psum_cnt, .result_cnt, .w_pe_cnt, .act_pe_cnt, .wait_cnt
    );

    mem_addr_gen #(.ADDR_W(ADDR_W)) u_mem_addr (
        .phase, .block, .row, .w_idx, .act_gb_cnt, .result_cnt, .mem_addr
    );

    gb_addr_gen #(.ADDR_W(ADDR_W)) u_gb_addr (
        .phase, .block, .row, .col, .w_idx, .act_gb_cnt, .w_pe_cnt, .act_pe_cnt,
        .psum_cnt, .result_cnt,
        .gb_addr_write, .gb_addr_psum, .gb_addr_mem, .gb_addr_pe
    );

endmodule

`default_nettype wire

//--- tb_conv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_ctrl;

    localparam int ADDR_W     = 12;
    localparam int PSUM_WAIT  = 12;
    localparam int CLK_PERIOD = 40;

    localparam int ACT_DIM    = conv_geom_pkg::ACT_DIM;
    localparam int FILT_DIM   = conv_geom_pkg::FILT_DIM;
    localparam int BLK_DIM    = conv_geom_pkg::BLK_DIM;
    localparam int OUT_DIM    = conv_geom_pkg::OUT_DIM;
    localparam int NUM_PE     = conv_geom_pkg::NUM_PE;
    localparam int LOAD_COLS  = conv_geom_pkg::ACT_LOAD_COLS;
    localparam int ACT_DEPTH  = conv_geom_pkg::GB_ACT_DEPTH;
    localparam int NUM_BLOCKS = conv_geom_pkg::NUM_BLOCKS;

    // Transfers of one block, in schedule order
    localparam int BLOCK_XFERS = BLK_DIM * BLK_DIM + LOAD_COLS * BLK_DIM + NUM_PE +
                                 OUT_DIM * NUM_PE + OUT_DIM * (OUT_DIM - 1) +
                                 OUT_DIM * OUT_DIM + (OUT_DIM - 1) * LOAD_COLS;
    localparam int XFER_TOTAL   = NUM_BLOCKS * BLOCK_XFERS + OUT_DIM * OUT_DIM;
    localparam int PSUM_WINDOWS = NUM_BLOCKS * OUT_DIM * OUT_DIM;
    localparam int LIMIT_NS     = (4 * XFER_TOTAL + 2 * PSUM_WAIT * PSUM_WINDOWS + 4000) *
                                  CLK_PERIOD;

    // Result groups, one report line each
    localparam int T_LOAD   = 0;
    localparam int T_PE     = 1;
    localparam int T_PSUM   = 2;
    localparam int T_REFILL = 3;
    localparam int T_RESET  = 4;
    localparam int T_WB     = 5;

    logic              clk;
    logic              rst;
    logic              done_mem;
    logic              done_gb;
    logic              read_mem;
    logic              write_mem;
    logic [ADDR_W-1:0] mem_addr;
    logic              read_gb;
    logic              write_pe_to_gb;
    logic              write_mem_to_gb;
    logic [ADDR_W-1:0] gb_addr_write;
    logic [ADDR_W-1:0] gb_addr_psum;
    logic [ADDR_W-1:0] gb_addr_mem;
    logic [ADDR_W-1:0] gb_addr_pe [NUM_PE];
    logic              init;
    logic              finished;

    // Reference schedule state
    ctrl_pkg::phase_e m_phase;
    int               m_blk;
    int               m_row;
    int               m_col;
    int               m_n;      // Transfer number inside the phase
    int               m_psum;
    int               m_test;
    logic [31:0]      lcg_state;

    int err_cnt;
    int chk_cnt;
    int test_err [6];
    int test_chk [6];

    conv_ctrl_top #(.ADDR_W(ADDR_W), .PSUM_WAIT(PSUM_WAIT)) DUT (
        .clk, .rst, .done_mem, .done_gb,
        .read_mem, .write_mem, .mem_addr,
        .read_gb, .write_pe_to_gb, .write_mem_to_gb,
        .gb_addr_write, .gb_addr_psum, .gb_addr_mem, .gb_addr_pe,
        .init, .finished
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state >> 16);
    endfunction

    function automatic string test_label(input int t);
        case (t)
            T_LOAD:   return "weight and activation load";
            T_PE:     return "PE read addresses";
            T_PSUM:   return "psum windows";
            T_REFILL: return "row refill";
            T_RESET:  return "init after reset";
            default:  return "writeback";
        endcase
    endfunction

    task automatic flag_failure(input string msg);
        $display("%0t: %s", $time, msg);
        err_cnt++;
        test_err[m_test]++;
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        chk_cnt++;
        test_chk[m_test]++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
            test_err[m_test]++;
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        chk_cnt++;
        test_chk[m_test]++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
            test_err[m_test]++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        chk_cnt++;
        test_chk[m_test]++;
        if (got != exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
            test_err[m_test]++;
        end
    endtask

    task automatic report_test(input int t, input string scope);
        $display("%s %s %s: %0d checks, %0d errors", (test_err[t] == 0) ? "[PASS]" : "[FAIL]",
                 scope, test_label(t), test_chk[t], test_err[t]);
        test_err[t] = 0;
        test_chk[t] = 0;
    endtask

    //////////////////////////////////////////////////
    // Expected outputs of the current transfer
    //////////////////////////////////////////////////
    task automatic check_outputs();
        int right;
        int lower;
        int pos;
        int act;

        right = (m_blk % 2) * BLK_DIM;   // Right block
        lower = (m_blk / 2) * BLK_DIM;   // Lower block, in rows
        case (m_phase)
            ctrl_pkg::LOAD_W, ctrl_pkg::LOAD_ACT, ctrl_pkg::REFILL_ROW: begin
                check_strobe("read_mem", read_mem, 1'b1);
                check_strobe("write_mem_to_gb", write_mem_to_gb, 1'b1);
                if (m_phase == ctrl_pkg::LOAD_W) begin
                    check_addr("mem_addr", mem_addr, ADDR_W'(conv_geom_pkg::MEM_W_BASE +
                        FILT_DIM * (m_n / BLK_DIM + lower) + m_n % BLK_DIM + right));
                    check_addr("gb_addr_write", gb_addr_write,
                        ADDR_W'(conv_geom_pkg::GB_W_BASE + m_n));
                end else if (m_phase == ctrl_pkg::LOAD_ACT) begin
                    act = ACT_DIM * (m_n / LOAD_COLS) + m_n % LOAD_COLS + right;
                    check_addr("mem_addr", mem_addr, ADDR_W'(act + ACT_DIM * lower));
                    check_addr("gb_addr_write", gb_addr_write, ADDR_W'(act));
                end else begin
                    act = ACT_DIM * m_row + m_n + right;
                    check_addr("mem_addr", mem_addr,
                        ADDR_W'(ACT_DEPTH + ACT_DIM * lower + act));
                    check_addr("gb_addr_write", gb_addr_write, ADDR_W'(act % ACT_DEPTH));
                end
            end
            ctrl_pkg::BCAST_W: begin
                check_strobe("read_gb", read_gb, 1'b1);
                for (int k = 0; k < NUM_PE; k++)
                    check_addr($sformatf("gb_addr_pe[%0d]", k), gb_addr_pe[k],
                        ADDR_W'(conv_geom_pkg::GB_W_BASE + m_n + BLK_DIM * k));
            end
            ctrl_pkg::STREAM_ACT, ctrl_pkg::STEP_COL: begin
                check_strobe("read_gb", read_gb, 1'b1);
                pos = (m_phase == ctrl_pkg::STEP_COL) ? m_col + BLK_DIM - 1 : m_n;
                for (int k = 0; k < NUM_PE; k++)
                    check_addr($sformatf("gb_addr_pe[%0d]", k), gb_addr_pe[k],
                        ADDR_W'((pos + ACT_DIM * (k + m_row) + right) % ACT_DEPTH));
            end
            ctrl_pkg::PSUM: begin
                check_strobe("write_pe_to_gb", write_pe_to_gb, 1'b1);
                check_strobe("read_gb", read_gb, 1'b0);
                check_addr("gb_addr_write", gb_addr_write,
                    ADDR_W'(conv_geom_pkg::GB_PSUM_BASE + m_psum));
                check_addr("gb_addr_psum", gb_addr_psum,
                    ADDR_W'(conv_geom_pkg::GB_PSUM_BASE + m_psum));
            end
            default: begin   // Writeback
                check_strobe("write_mem", write_mem, 1'b1);
                check_strobe("read_gb", read_gb, 1'b1);
                check_addr("mem_addr", mem_addr, ADDR_W'(conv_geom_pkg::MEM_PSUM_BASE + m_n));
                check_addr("gb_addr_mem", gb_addr_mem,
                    ADDR_W'(conv_geom_pkg::GB_PSUM_BASE + m_n));
            end
        endcase
    endtask

    // One transfer, completed by a single done pulse after 0 to 3 idle cycles
    task automatic pulse_done(input logic on_mem);
        int   delay;
        logic strobe_ok;

        delay = next_rand() % 4;
        repeat (delay) @(posedge clk);
        @(negedge clk);
        check_outputs();
        strobe_ok = on_mem ? (read_mem | write_mem) : (read_gb | write_pe_to_gb);
        @(posedge clk);
        if (strobe_ok === 1'b1) begin
            if (on_mem)
                done_mem <= 1'b1;
            else
                done_gb <= 1'b1;
        end else begin
            flag_failure("no transfer strobe is high, done pulse withheld");
        end
        @(posedge clk);
        done_mem <= 1'b0;
        done_gb  <= 1'b0;
    endtask

    task automatic psum_window();
        int rd_cycles;
        int guard;

        rd_cycles = 0;
        guard     = 0;
        m_test    = T_PSUM;
        @(negedge clk);   // SHIFT
        check_strobe("read_gb", read_gb, 1'b0);
        check_strobe("write_pe_to_gb", write_pe_to_gb, 1'b0);
        while (write_pe_to_gb !== 1'b1 && guard < 4 * PSUM_WAIT) begin
            @(negedge clk);
            if (read_gb === 1'b1 && write_pe_to_gb !== 1'b1)
                rd_cycles++;
            guard++;
        end
        if (write_pe_to_gb !== 1'b1)
            flag_failure("write_pe_to_gb never rose after the psum wait");
        check_count("read_gb cycles before write_pe_to_gb", rd_cycles, PSUM_WAIT);
        m_phase = ctrl_pkg::PSUM;
        pulse_done(1'b0);
        m_psum++;
    endtask

    //////////////////////////////////////////////////
    // Schedule
    //////////////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        done_mem  = 1'b0;
        done_gb   = 1'b0;
        lcg_state = 32'hf6ee;
        err_cnt   = 0;
        chk_cnt   = 0;
        m_test    = T_RESET;
        m_phase   = ctrl_pkg::INIT;
        for (int t = 0; t < 6; t++) begin
            test_err[t] = 0;
            test_chk[t] = 0;
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_strobe("init", init, 1'b1);
        check_strobe("read_mem", read_mem, 1'b0);
        check_strobe("write_mem", write_mem, 1'b0);
        check_strobe("read_gb", read_gb, 1'b0);
        check_strobe("write_pe_to_gb", write_pe_to_gb, 1'b0);
        check_strobe("write_mem_to_gb", write_mem_to_gb, 1'b0);
        check_strobe("finished", finished, 1'b0);
        @(negedge clk);
        check_strobe("init", init, 1'b0);   // Gone after one cycle
        report_test(T_RESET, "reset:");

        for (int b = 0; b < NUM_BLOCKS; b++) begin
            m_blk  = b;
            m_row  = 0;
            m_col  = 0;
            m_psum = 0;
            m_test = T_LOAD;
            m_phase = ctrl_pkg::LOAD_W;
            for (int n = 0; n < BLK_DIM * BLK_DIM; n++) begin
                m_n = n;
                pulse_done(1'b1);
            end
            m_phase = ctrl_pkg::LOAD_ACT;
            for (int n = 0; n < LOAD_COLS * BLK_DIM; n++) begin
                m_n = n;
                pulse_done(1'b1);
            end
            m_test  = T_PE;
            m_phase = ctrl_pkg::BCAST_W;
            for (int n = 0; n < NUM_PE; n++) begin
                m_n = n;
                pulse_done(1'b0);
            end

            for (int r = 0; r < OUT_DIM; r++) begin
                m_row   = r;
                m_col   = 0;
                m_test  = T_PE;
                m_phase = ctrl_pkg::STREAM_ACT;
                for (int n = 0; n < NUM_PE; n++) begin
                    m_n = n;
                    pulse_done(1'b0);
                end
                psum_window();
                for (int c = 1; c < OUT_DIM; c++) begin
                    m_col   = c;
                    m_test  = T_PE;
                    m_phase = ctrl_pkg::STEP_COL;
                    pulse_done(1'b0);
                    psum_window();
                end
                if (r < OUT_DIM - 1) begin
                    m_test  = T_REFILL;
                    m_phase = ctrl_pkg::REFILL_ROW;
                    for (int n = 0; n < LOAD_COLS; n++) begin
                        m_n = n;
                        pulse_done(1'b1);
                    end
                end
            end
            for (int t = T_LOAD; t <= T_REFILL; t++)
                report_test(t, $sformatf("block %0d", b));
        end

        m_test  = T_WB;
        m_phase = ctrl_pkg::WRITEBACK;
        for (int n = 0; n < OUT_DIM * OUT_DIM; n++) begin
            m_n = n;
            pulse_done(1'b1);
        end
        // Finished must rise at once and stay
        repeat (4) begin
            @(negedge clk);
            check_strobe("finished", finished, 1'b1);
            check_strobe("write_mem", write_mem, 1'b0);
            check_strobe("read_gb", read_gb, 1'b0);
        end
        report_test(T_WB, "end of run");

        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("watchdog: no end of schedule after %0d ns, the DUT stopped responding",
                 LIMIT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_ctrl_top.f
conv_geom_pkg.sv
ctrl_pkg.sv
conv_sequencer.sv
transfer_counters.sv
mem_addr_gen.sv
gb_addr_gen.sv
conv_ctrl_top.sv
tb_conv_ctrl.sv

//--- Makefile
TOP = tb_conv_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f conv_ctrl_top.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
